// File: Bender.yml
package:
  name: dram_axi_bridge

sources:
  - dram_ctrl_pkg.sv
  - axi_read_port.sv
  - axi_write_port.sv
  - dram_arbiter.sv
  - dram_sequencer.sv
  - dram_axi_bridge.sv
  - target: test
    files:
      - tb_dram_model.sv
      - tb_dram_axi.sv

// File: axi_read_port.sv
/* AXI read port: AR/R channel engine that walks an INCR burst
   one word request at a time */
`timescale 1ns/10ps
module axi_read_port import dram_ctrl_pkg::*; (
    input  logic              ACLK,
    input  logic              ARESETn,
    input  logic              ar_valid,
    input  axi_ar_t           ar,
    input  logic              r_ready,
    input  logic              gnt,
    input  logic              done,
    input  logic [DATA_W-1:0] rdata_in,
    output logic              ar_ready,
    output logic              r_valid,
    output logic [DATA_W-1:0] r_data,
    output logic [ID_W-1:0]   r_id,
    output logic              r_last,
    output logic              req,
    output dram_req_t         req_data
);

    rd_state_e        state;
    logic [LEN_W-1:0] beat;
    logic [LEN_W-1:0] len_q;
    logic [ID_W-1:0]  id_q;
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    logic             r_hs;

    assign r_hs = r_valid && r_ready;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= RD_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    beat <= '0;
                    if (ar_valid)
                        state <= RD_REQ;
                end
                RD_REQ:  if (gnt) state <= RD_WAIT;
                RD_WAIT: if (done) state <= RD_DATA;
                RD_DATA: begin
                    if (r_hs) begin
                        if (r_last) begin
                            state <= RD_IDLE;
                        end else begin
                            beat  <= beat + 1'b1;
                            state <= RD_REQ;   // Next beat only after R handshake
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Burst payload and returned word
    always_ff @(posedge ACLK) begin
        if (ar_valid && ar_ready) begin
            id_q  <= ar.id;
            len_q <= ar.len;
            row_q <= ar.addr[ROW_LSB +: ROW_W];
            col_q <= ar.addr[COL_LSB +: COL_W];
        end else if (r_hs) begin
            col_q <= col_q + 1'b1;
        end
        if (state == RD_WAIT && done)
            r_data <= rdata_in;
    end

    assign ar_ready = (state == RD_IDLE);
    assign r_valid  = (state == RD_DATA);
    assign r_id     = id_q;
    assign r_last   = r_valid && (beat == len_q);
    assign req      = (state == RD_REQ);

    always_comb begin
        req_data       = '0;
        req_data.write = 1'b0;
        req_data.row   = row_q;
        req_data.col   = col_q;
    end

    // A stalled beat keeps its data and last flag until accepted
    a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_last));

endmodule

// File: axi_write_port.sv
/* AXI write port: AW/W/B channel engine for single-beat
   writes with byte strobes */
`timescale 1ns/10ps
module axi_write_port import dram_ctrl_pkg::*; (
    input  logic            ACLK,
    input  logic            ARESETn,
    input  logic            aw_valid,
    input  axi_aw_t         aw,
    input  logic            w_valid,
    input  axi_w_t          w,
    input  logic            b_ready,
    input  logic            gnt,
    input  logic            done,
    output logic            aw_ready,
    output logic            w_ready,
    output logic            b_valid,
    output logic [ID_W-1:0] b_id,
    output logic            req,
    output dram_req_t       req_data
);

    wr_state_e         state;
    logic [ID_W-1:0]   id_q;
    logic [ROW_W-1:0]  row_q;
    logic [COL_W-1:0]  col_q;
    logic [DATA_W-1:0] data_q;
    logic [STRB_W-1:0] strb_q;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (aw_valid) state <= WR_DATA;
                WR_DATA: if (w_valid) state <= WR_REQ;
                WR_REQ:  if (gnt) state <= WR_WAIT;
                WR_WAIT: if (done) state <= WR_RESP;
                WR_RESP: if (b_ready) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_valid && aw_ready) begin
            id_q  <= aw.id;
            row_q <= aw.addr[ROW_LSB +: ROW_W];
            col_q <= aw.addr[COL_LSB +: COL_W];
        end
        if (w_valid && w_ready) begin
            data_q <= w.data;
            strb_q <= w.strb;
        end
    end

    assign aw_ready = (state == WR_IDLE);
    assign w_ready  = (state == WR_DATA);
    assign b_valid  = (state == WR_RESP);  // Held until b_ready
    assign b_id     = id_q;
    assign req      = (state == WR_REQ);

    always_comb begin
        req_data.write = 1'b1;
        req_data.row   = row_q;
        req_data.col   = col_q;
        req_data.wdata = data_q;
        req_data.wstrb = strb_q;
    end

endmodule

// File: dram_arbiter.sv
/* Read-priority arbiter that hands one request at a time to
   the sequencer and steers its done back to the owner */
`timescale 1ns/10ps
module dram_arbiter import dram_ctrl_pkg::*; (
    input  logic      ACLK,
    input  logic      ARESETn,
    input  logic      rd_req,
    input  dram_req_t rd_req_data,
    input  logic      wr_req,
    input  dram_req_t wr_req_data,
    input  logic      seq_done,
    output logic      rd_gnt,
    output logic      wr_gnt,
    output logic      rd_done,
    output logic      wr_done,
    output logic      start,
    output dram_req_t start_req
);

    logic busy;
    logic owner_rd;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            busy     <= 1'b0;
            owner_rd <= 1'b0;
            rd_gnt   <= 1'b0;
            wr_gnt   <= 1'b0;
            start    <= 1'b0;
        end else begin
            rd_gnt <= 1'b0;
            wr_gnt <= 1'b0;
            start  <= 1'b0;
            if (busy) begin
                if (seq_done)
                    busy <= 1'b0;
            end else if (rd_req || wr_req) begin
                rd_gnt   <= rd_req;  // Read wins a tie
                wr_gnt   <= !rd_req;
                owner_rd <= rd_req;
                start    <= 1'b1;
                busy     <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (!busy)
            start_req <= rd_req ? rd_req_data : wr_req_data;
    end

    assign rd_done = seq_done && busy && owner_rd;
    assign wr_done = seq_done && busy && !owner_rd;

    // One grant at a time, never back to back
    a_one_gnt: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rd_gnt || wr_gnt) |-> !(rd_gnt && wr_gnt) ##1 !(rd_gnt || wr_gnt));

endmodule

// File: dram_axi_bridge.sv
/* AXI to DRAM bridge top: read and write ports sharing one
   command sequencer through a read-priority arbiter */
`timescale 1ns/10ps
module dram_axi_bridge import dram_ctrl_pkg::*; (
    input  logic              ACLK,
    input  logic              ARESETn,
    input  logic              ar_valid,
    input  axi_ar_t           ar,
    output logic              ar_ready,
    output logic              r_valid,
    output logic [DATA_W-1:0] r_data,
    output logic [ID_W-1:0]   r_id,
    output logic              r_last,
    input  logic              r_ready,
    input  logic              aw_valid,
    input  axi_aw_t           aw,
    output logic              aw_ready,
    input  logic              w_valid,
    input  axi_w_t            w,
    output logic              w_ready,
    output logic              b_valid,
    output logic [ID_W-1:0]   b_id,
    input  logic              b_ready,
    output dram_pins_t        dram_pins,
    input  logic [DATA_W-1:0] dram_q,
    input  logic              dram_valid
);

    logic              rd_req, rd_gnt, rd_done;
    logic              wr_req, wr_gnt, wr_done;
    dram_req_t         rd_req_data, wr_req_data, start_req;
    logic              start, seq_done;
    logic [DATA_W-1:0] seq_rdata;

    axi_read_port u_rd (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .ar_valid(ar_valid), .ar(ar), .r_ready(r_ready),
        .gnt(rd_gnt), .done(rd_done), .rdata_in(seq_rdata),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_data(r_data),
        .r_id(r_id), .r_last(r_last), .req(rd_req), .req_data(rd_req_data)
    );

    axi_write_port u_wr (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .aw_valid(aw_valid), .aw(aw), .w_valid(w_valid), .w(w), .b_ready(b_ready),
        .gnt(wr_gnt), .done(wr_done),
        .aw_ready(aw_ready), .w_ready(w_ready), .b_valid(b_valid), .b_id(b_id),
        .req(wr_req), .req_data(wr_req_data)
    );

    dram_arbiter u_arb (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .rd_req(rd_req), .rd_req_data(rd_req_data),
        .wr_req(wr_req), .wr_req_data(wr_req_data), .seq_done(seq_done),
        .rd_gnt(rd_gnt), .wr_gnt(wr_gnt), .rd_done(rd_done), .wr_done(wr_done),
        .start(start), .start_req(start_req)
    );

    dram_sequencer u_seq (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .start(start), .start_req(start_req),
        .dram_q(dram_q), .dram_valid(dram_valid),
        .done(seq_done), .rdata(seq_rdata), .dram_pins(dram_pins)
    );

endmodule

// File: dram_cases.txt
# op id addr len wdata strb, then len+1 expected read words (R and T only), then added precharges
# W single write, R read burst, T read and write raised together (read sees the old word)
W 01 00001010 0 a5a51234 f 0
R 02 00001010 0 0 0 a5a51234 0
W 03 00001010 0 0000c0de 3 0
R 04 00001010 0 0 0 a5a5c0de 0
W 05 00002000 0 11111111 f 1
W 06 00002004 0 22222222 f 0
W 07 00002008 0 33333333 f 0
W 08 0000200c 0 44444444 f 0
R 09 00002000 3 0 0 11111111 22222222 33333333 44444444 0
R 0a 00001008 7 0 0 0 0 a5a5c0de 0 0 0 0 0 1
W 0b 00003ffc 0 12345678 c 1
R 0c 00003ff0 3 0 0 0 0 0 12340000 0
T 0d 00003ffc 0 9abcdef0 f 12340000 0
R 0e 00003ffc 0 0 0 9abcdef0 0
R 0f 00002000 f 0 0 11111111 22222222 33333333 44444444 0 0 0 0 0 0 0 0 0 0 0 0 1
W 10 00001010 0 ffffffff 1 1
R 11 00001010 0 0 0 a5a5c0ff 0

// File: dram_ctrl_pkg.sv
/* Widths, address fields, timing constants, payload structs
   and state enums shared by the AXI to DRAM bridge */
package dram_ctrl_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int ID_W   = 8;
    localparam int LEN_W  = 4;
    localparam int STRB_W = 4;

    // Row is addr[22:12], word column is addr[11:2]
    localparam int ROW_W    = 11;
    localparam int ROW_LSB  = 12;
    localparam int COL_W    = 10;
    localparam int COL_LSB  = 2;
    localparam int DRAM_A_W = 11;

    localparam int T_RP  = 3;  // Cycles after precharge
    localparam int T_RCD = 3;  // Activate to column
    localparam int T_WR  = 3;  // Write recovery
    localparam int CNT_W = 3;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    // One word operation handed to the sequencer
    typedef struct packed {
        logic              write;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } dram_req_t;

    typedef struct packed {
        logic                csn;
        logic [STRB_W-1:0]   wen;   // Active low byte enables
        logic                rasn;
        logic                casn;
        logic [DRAM_A_W-1:0] a;
        logic [DATA_W-1:0]   d;
    } dram_pins_t;

    typedef enum logic [2:0] {NOP, PRECHARGE, ACTIVATE, COL_READ, COL_WRITE} dram_cmd_e;

    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_PRE, SEQ_WAIT_RP, SEQ_ACT,
        SEQ_WAIT_RCD, SEQ_COL, SEQ_WAIT_RD, SEQ_WAIT_WR
    } seq_state_e;

    typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT, RD_DATA} rd_state_e;

    typedef enum logic [2:0] {WR_IDLE, WR_DATA, WR_REQ, WR_WAIT, WR_RESP} wr_state_e;

endpackage

// File: dram_sequencer.sv
/* DRAM command sequencer with open-row tracking, a shared wait
   counter and command to pin decoding */
`timescale 1ns/10ps
module dram_sequencer import dram_ctrl_pkg::*; (
    input  logic              ACLK,
    input  logic              ARESETn,
    input  logic              start,
    input  dram_req_t         start_req,
    input  logic [DATA_W-1:0] dram_q,
    input  logic              dram_valid,
    output logic              done,
    output logic [DATA_W-1:0] rdata,
    output dram_pins_t        dram_pins
);

    seq_state_e       state;
    dram_req_t        req_q;
    logic [ROW_W-1:0] open_row;
    logic             row_open;
    logic             row_hit;
    logic [CNT_W-1:0] cnt;
    dram_cmd_e        cmd;

    assign row_hit = row_open && (open_row == start_req.row);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state    <= SEQ_IDLE;
            row_open <= 1'b0;
            cnt      <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        if (row_hit)
                            state <= SEQ_COL;
                        else if (row_open)
                            state <= SEQ_PRE;
                        else
                            state <= SEQ_ACT;  // Nothing open, skip precharge
                    end
                end
                SEQ_PRE: begin
                    row_open <= 1'b0;
                    cnt      <= CNT_W'(T_RP - 1);
                    state    <= SEQ_WAIT_RP;
                end
                SEQ_WAIT_RP: begin
                    if (cnt == '0)
                        state <= SEQ_ACT;
                    else
                        cnt <= cnt - 1'b1;
                end
                SEQ_ACT: begin
                    row_open <= 1'b1;
                    cnt      <= CNT_W'(T_RCD - 1);
                    state    <= SEQ_WAIT_RCD;
                end
                SEQ_WAIT_RCD: begin
                    if (cnt == '0)
                        state <= SEQ_COL;
                    else
                        cnt <= cnt - 1'b1;
                end
                SEQ_COL: begin
                    if (req_q.write) begin
                        cnt   <= CNT_W'(T_WR - 1);
                        state <= SEQ_WAIT_WR;
                    end else begin
                        state <= SEQ_WAIT_RD;
                    end
                end
                SEQ_WAIT_WR: begin
                    if (cnt == '0)
                        state <= SEQ_IDLE;
                    else
                        cnt <= cnt - 1'b1;
                end
                SEQ_WAIT_RD: if (dram_valid) state <= SEQ_IDLE;
                default:     state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (start && state == SEQ_IDLE)
            req_q <= start_req;
        if (state == SEQ_ACT)
            open_row <= req_q.row;
    end

    // Write done lands T_WR cycles after the column write
    assign done  = (state == SEQ_WAIT_WR && cnt == '0) || (state == SEQ_WAIT_RD && dram_valid);
    assign rdata = dram_q;

    always_comb begin
        cmd = NOP;
        if (state == SEQ_PRE)
            cmd = PRECHARGE;
        else if (state == SEQ_ACT)
            cmd = ACTIVATE;
        else if (state == SEQ_COL && req_q.write)
            cmd = COL_WRITE;
        else if (state == SEQ_COL)
            cmd = COL_READ;
    end

    always_comb begin
        dram_pins.csn  = 1'b0;
        dram_pins.wen  = '1;
        dram_pins.rasn = 1'b1;
        dram_pins.casn = 1'b1;
        dram_pins.a    = '0;
        dram_pins.d    = '0;
        case (cmd)
            PRECHARGE: begin
                dram_pins.wen  = '0;
                dram_pins.rasn = 1'b0;
                dram_pins.a    = open_row;
            end
            ACTIVATE: begin
                dram_pins.rasn = 1'b0;
                dram_pins.a    = req_q.row;
            end
            COL_READ: begin
                dram_pins.casn = 1'b0;
                dram_pins.a    = DRAM_A_W'(req_q.col);
            end
            COL_WRITE: begin
                dram_pins.casn = 1'b0;
                dram_pins.wen  = ~req_q.wstrb;  // Strobes are active high on AXI
                dram_pins.a    = DRAM_A_W'(req_q.col);
                dram_pins.d    = req_q.wdata;
            end
            default: ;
        endcase
    end

    // Activate on the pins only once the previous row is closed
    a_act_closed: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !dram_pins.rasn && dram_pins.casn && (&dram_pins.wen) |-> !row_open);

endmodule

// File: src.f
dram_ctrl_pkg.sv
axi_read_port.sv
axi_write_port.sv
dram_arbiter.sv
dram_sequencer.sv
dram_axi_bridge.sv
tb_dram_model.sv
tb_dram_axi.sv

// File: tb_dram_axi.sv
/* Testbench top: replays the cases file through the AXI ports with random
   R and B back-pressure and checks data, IDs, RLAST and precharge counts */
`timescale 1ns/10ps
module tb_dram_axi import dram_ctrl_pkg::*; ();

    logic              ACLK;
    logic              ARESETn;
    logic              ar_valid, r_ready, aw_valid, w_valid, b_ready;
    axi_ar_t           ar;
    axi_aw_t           aw;
    axi_w_t            w;
    logic              ar_ready, r_valid, r_last, aw_ready, w_ready, b_valid;
    logic [DATA_W-1:0] r_data, dram_q;
    logic [ID_W-1:0]   r_id, b_id;
    logic              dram_valid, proto_err;
    dram_pins_t        dram_pins;
    int                pre_count;

    byte               c_op [$];
    logic [ID_W-1:0]   c_id [$];
    logic [ADDR_W-1:0] c_addr [$];
    logic [LEN_W-1:0]  c_len [$];
    logic [DATA_W-1:0] c_data [$];
    logic [STRB_W-1:0] c_strb [$];
    int                c_pre [$];
    logic [DATA_W-1:0] exp_words [$];  // Read words of all cases, in order
    int                cycle_count;
    int                cycle_limit;
    logic [31:0]       lfsr;

    dram_axi_bridge uut (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_id(r_id), .r_last(r_last), .r_ready(r_ready),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
        .w_valid(w_valid), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b_id(b_id), .b_ready(b_ready),
        .dram_pins(dram_pins), .dram_q(dram_q), .dram_valid(dram_valid)
    );

    tb_dram_model mem_model (
        .ACLK(ACLK), .pins(dram_pins), .q(dram_q), .q_valid(dram_valid),
        .pre_count(pre_count), .proto_err(proto_err)
    );

    initial begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(posedge ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            abort_run("Timeout: the bridge stopped responding before all cases finished");
        if (proto_err)
            abort_run("The DRAM model saw an illegal command sequence on the pins");
    end

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp_v,
                              input logic [DATA_W-1:0] act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v));
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] exp_v,
                            input logic [ID_W-1:0] act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v));
    endtask

    task automatic check_last(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp_v, act_v));
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v)
            abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp_v, act_v));
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic load_cases();
        int                fd, code, pre;
        byte               op;
        logic [8*128-1:0]  skip;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [DATA_W-1:0] wdata, word;
        logic [STRB_W-1:0] strb;
        fd = $fopen("dram_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open dram_cases.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1)
                    break;
                if (op == "#") begin
                    code = $fgets(skip, fd);
                    continue;
                end
                code = $fscanf(fd, "%h %h %h %h %h", id, addr, len, wdata, strb);
                c_op.push_back(op);
                c_id.push_back(id);
                c_addr.push_back(addr);
                c_len.push_back(len);
                c_data.push_back(wdata);
                c_strb.push_back(strb);
                if (op != "W") begin
                    for (int i = 0; i <= len; i++) begin
                        code = $fscanf(fd, "%h", word);
                        exp_words.push_back(word);
                    end
                end
                code = $fscanf(fd, "%d", pre);
                c_pre.push_back(pre);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_read(input int idx, input int base);
        int d;
        @(negedge ACLK);
        ar_valid = 1'b1;
        ar.id    = c_id[idx];
        ar.addr  = c_addr[idx];
        ar.len   = c_len[idx];
        while (!ar_ready) @(negedge ACLK);
        @(negedge ACLK);
        ar_valid = 1'b0;
        for (int b = 0; b <= c_len[idx]; b++) begin
            while (!r_valid) @(negedge ACLK);
            rand_bits(3, d);
            repeat (d) @(negedge ACLK);  // Stall the beat
            r_ready = 1'b1;
            check_data($sformatf("case %0d beat %0d data", idx, b), exp_words[base + b], r_data);
            check_id($sformatf("case %0d beat %0d RID", idx, b), c_id[idx], r_id);
            check_last($sformatf("case %0d beat %0d RLAST", idx, b), b == c_len[idx], r_last);
            @(negedge ACLK);
            r_ready = 1'b0;
        end
    endtask

    task automatic run_write(input int idx);
        int d;
        @(negedge ACLK);
        aw_valid = 1'b1;
        aw.id    = c_id[idx];
        aw.addr  = c_addr[idx];
        while (!aw_ready) @(negedge ACLK);
        @(negedge ACLK);
        aw_valid = 1'b0;
        w_valid  = 1'b1;
        w.data   = c_data[idx];
        w.strb   = c_strb[idx];
        while (!w_ready) @(negedge ACLK);
        @(negedge ACLK);
        w_valid = 1'b0;
        while (!b_valid) @(negedge ACLK);
        rand_bits(3, d);
        repeat (d) @(negedge ACLK);
        b_ready = 1'b1;
        check_id($sformatf("case %0d BID", idx), c_id[idx], b_id);
        @(negedge ACLK);
        b_ready = 1'b0;
    endtask

    initial begin
        int base;
        int pre_before;
        ARESETn     = 1'b0;
        ar_valid    = 1'b0;
        ar          = '0;
        r_ready     = 1'b0;
        aw_valid    = 1'b0;
        aw          = '0;
        w_valid     = 1'b0;
        w           = '0;
        b_ready     = 1'b0;
        lfsr        = 32'he3f2;
        cycle_count = 0;
        cycle_limit = 0;
        base        = 0;
        load_cases();
        cycle_limit = 200 * c_op.size();
        repeat (2) @(negedge ACLK);
        ARESETn = 1'b1;
        for (int idx = 0; idx < c_op.size(); idx++) begin
            pre_before = pre_count;
            case (c_op[idx])
                "W": run_write(idx);
                "R": run_read(idx, base);
                default: begin  // AR and AW raised in the same cycle
                    fork
                        run_read(idx, base);
                        run_write(idx);
                    join
                end
            endcase
            if (c_op[idx] != "W")
                base += c_len[idx] + 1;
            check_count($sformatf("case %0d precharges", idx), c_pre[idx], pre_count - pre_before);
        end
        @(negedge ACLK);
        if (proto_err) begin
            abort_run("The DRAM model saw an illegal command sequence on the pins");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: tb_dram_model.sv
/* Behavioral single-bank DRAM model with word storage, a two-cycle read
   latency, a precharge counter and a protocol monitor */
`timescale 1ns/10ps
module tb_dram_model import dram_ctrl_pkg::*; (
    input  logic              ACLK,
    input  dram_pins_t        pins,
    output logic [DATA_W-1:0] q,
    output logic              q_valid,
    output int                pre_count,
    output logic              proto_err
);

    bit [DATA_W-1:0]   mem [0:(1 << (ROW_W + COL_W)) - 1];  // Row and column, starts at zero
    logic              row_act;
    logic [ROW_W-1:0]  act_row;
    logic [1:0]        rd_pipe;
    logic [DATA_W-1:0] q_pipe [0:1];

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [STRB_W-1:0] wen);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++)
            if (!wen[b])
                res[8*b +: 8] = new_w[8*b +: 8];  // Active low byte enable
        return res;
    endfunction

    initial begin
        q         = '0;
        q_valid   = 1'b0;
        pre_count = 0;
        proto_err = 1'b0;
        row_act   = 1'b0;
        rd_pipe   = '0;
    end

    always @(posedge ACLK) begin
        rd_pipe   <= {rd_pipe[0], 1'b0};
        q_pipe[1] <= q_pipe[0];
        if (!pins.csn && !pins.rasn && pins.casn) begin
            if (pins.wen == '0) begin  // Precharge
                row_act   <= 1'b0;
                pre_count <= pre_count + 1;
            end else if (row_act) begin
                $display("DRAM model: activate of row %0d while row %0d is still open",
                         pins.a, act_row);
                proto_err <= 1'b1;
            end else begin
                row_act <= 1'b1;
                act_row <= pins.a;
            end
        end else if (!pins.csn && pins.rasn && !pins.casn) begin
            if (!row_act) begin
                $display("DRAM model: column command at column %0d with no activated row",
                         pins.a);
                proto_err <= 1'b1;
            end else if (&pins.wen) begin
                rd_pipe   <= {rd_pipe[0], 1'b1};
                q_pipe[0] <= mem[{act_row, pins.a[COL_W-1:0]}];
            end else begin
                mem[{act_row, pins.a[COL_W-1:0]}] <=
                    merge_bytes(mem[{act_row, pins.a[COL_W-1:0]}], pins.d, pins.wen);
            end
        end
    end

    // Read word shows up two cycles after the column read
    always @(negedge ACLK) begin
        q_valid <= rd_pipe[1];
        q       <= q_pipe[1];
    end

endmodule
